//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

obj_dir/Vclock_meter_tb: sources.f rtl/*.sv bench/*.sv
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module clock_meter_tb -Mdir obj_dir

test: obj_dir/Vclock_meter_tb
	@out="$$(./obj_dir/Vclock_meter_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

//--- bench/clock_meter_tb.sv
`timescale 1ns/1ps
`default_nettype none

module clock_meter_tb
	import clock_meter_pkg::*;
();

	localparam int clk_period = 10;
	localparam int period_a = 8;
	localparam int period_b = 14;
	localparam int tolerance = 2;
	localparam int num_random = 4;
	// two more lengths for the start-while-busy test
	localparam int num_lens = num_random + 2;

	logic                  s_clk_in = 1'b0;
	logic                  s_reset_in;
	logic [addr_width-1:0] address;
	logic                  read;
	logic                  write;
	logic [data_width-1:0] writedata;
	logic [data_width-1:0] readdata;
	logic                  clk_a = 1'b0;
	logic                  clk_b = 1'b0;

	integer      seed;
	int unsigned lens [num_lens];
	int          cycles = 0;
	int          cycle_limit = 1000000;
	int          errors = 0;
	int          errors_at_start = 0;
	int          tests_run = 0;
	int          tests_passed = 0;
	string       test_name = "none";
	int unsigned last_a = 0;
	int unsigned last_b = 0;

	logic dut_busy;
	logic dut_valid;
	logic dut_gate;

	clock_meter_top clock_meter_top_inst (
		.s_clk_in   (s_clk_in),
		.s_reset_in (s_reset_in),
		.address    (address),
		.read       (read),
		.write      (write),
		.writedata  (writedata),
		.readdata   (readdata),
		.clk_a      (clk_a),
		.clk_b      (clk_b)
	);

	always #(clk_period / 2) s_clk_in = ~s_clk_in;
	always #(period_a / 2) clk_a = ~clk_a;
	always #(period_b / 2) clk_b = ~clk_b;

	assign dut_busy = clock_meter_top_inst.busy;
	assign dut_valid = clock_meter_top_inst.valid;
	assign dut_gate = clock_meter_top_inst.gate;

	// busy ends one cycle after the counts are captured
	assert property (@(posedge s_clk_in) disable iff (s_reset_in)
		$rose(dut_valid) |=> $fell(dut_busy))
	else
	begin
		$display("busy did not fall one cycle after valid rose, at %0t", $time);
		errors++;
	end

	assert property (@(posedge s_clk_in) disable iff (s_reset_in)
		$fell(dut_busy) |-> dut_valid)
	else
	begin
		$display("busy fell before the counts were valid, at %0t", $time);
		errors++;
	end

	assert property (@(posedge s_clk_in) disable iff (s_reset_in)
		$rose(dut_gate) |-> $rose(dut_busy))
	else
	begin
		$display("gate opened without busy rising with it, at %0t", $time);
		errors++;
	end

	// readdata only moves one cycle after a read strobe
	assert property (@(posedge s_clk_in) disable iff (s_reset_in)
		!read |=> $stable(readdata))
	else
	begin
		$display("readdata changed without a read strobe, at %0t", $time);
		errors++;
	end

	always @(posedge s_clk_in)
	begin
		cycles++;
		if (cycles >= cycle_limit)
		begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("sim failed");
			$finish;
		end
	end

	function automatic int unsigned expected_count(input int unsigned len, input int period);
		// gate lasts len bus cycles of clk_period ns
		return len * clk_period / period;
	endfunction

	function automatic logic [data_width-1:0] expected_reg(input int addr);
		case (addr)
			0: return 32'h2;
			1: return last_a;
			2: return last_b;
			default: return lens[num_random];
		endcase
	endfunction

	task automatic check_value(input string what, input logic [data_width-1:0] expected,
		input logic [data_width-1:0] actual);
		assert (actual == expected)
		else
		begin
			$display("ERR %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
			errors++;
		end
	endtask

	task automatic check_count(input string what, input int unsigned expected,
		input int unsigned actual);
		assert ((actual + tolerance >= expected) && (actual <= expected + tolerance))
		else
		begin
			$display("ERR %s %s: expected %0d +/- %0d, actual %0d", test_name, what,
				expected, tolerance, actual);
			errors++;
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		errors_at_start = errors;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors == errors_at_start)
		begin
			tests_passed++;
			$display("test %s: ok", test_name);
		end
		else
		begin
			$display("test %s: %0d errors", test_name, errors - errors_at_start);
		end
	endtask

	task automatic write_reg(input logic [addr_width-1:0] addr,
		input logic [data_width-1:0] data);
		@(negedge s_clk_in);
		address = addr;
		writedata = data;
		write = 1'b1;
		@(negedge s_clk_in);
		write = 1'b0;
	endtask

	// data is registered, so it is there one cycle after the strobe
	task automatic read_reg(input logic [addr_width-1:0] addr,
		output logic [data_width-1:0] value);
		@(negedge s_clk_in);
		address = addr;
		read = 1'b1;
		@(negedge s_clk_in);
		read = 1'b0;
		value = readdata;
	endtask

	task automatic wait_valid();
		logic [data_width-1:0] status;
		status = '0;
		while (!status[status_valid_bit])
		begin
			read_reg(reg_start, status);
			if (!status[status_valid_bit])
				check_value("busy while measuring", 1, data_width'(status[status_busy_bit]));
		end
		// busy drops one cycle after valid, so read once more
		read_reg(reg_start, status);
		check_value("status after capture", 32'h2, status);
	endtask

	task automatic run_measurement(input int unsigned len);
		logic [data_width-1:0] value;
		write_reg(reg_start, len);
		read_reg(reg_start, value);
		check_value("busy after start", 1, data_width'(value[status_busy_bit]));
		wait_valid();
	endtask

	task automatic check_results(input int unsigned len);
		logic [data_width-1:0] value;
		read_reg(reg_count_a, value);
		last_a = value;
		check_count("count_a", expected_count(len, period_a), value);
		read_reg(reg_count_b, value);
		last_b = value;
		check_count("count_b", expected_count(len, period_b), value);
		read_reg(reg_gate, value);
		check_value("gate length", len, value);
	endtask

	initial
	begin
		int unsigned           total;
		logic [data_width-1:0] value;
		s_reset_in = 1'b1;
		address = '0;
		read = 1'b0;
		write = 1'b0;
		writedata = '0;
		seed = 32'hb9f6c49d;
		total = 0;
		for (int i = 0; i < num_lens; i++)
		begin
			lens[i] = 50 + ({$random(seed)} % 451);
			total += lens[i];
		end
		cycle_limit = total * 3 + 2000;

		repeat (8) @(posedge s_clk_in);
		@(negedge s_clk_in);
		s_reset_in = 1'b0;

		begin_test("reset_values");
		check_value("readdata after reset", 0, readdata);
		read_reg(reg_start, value);
		check_value("status after reset", 0, value);
		end_test();

		for (int i = 0; i < num_random; i++)
		begin
			begin_test($sformatf("measure_%0d", i));
			run_measurement(lens[i]);
			check_results(lens[i]);
			end_test();
		end

		// second start lands while the first is still busy
		begin_test("start_while_busy");
		write_reg(reg_start, lens[num_random]);
		write_reg(reg_start, lens[num_random + 1]);
		wait_valid();
		check_results(lens[num_random]);
		end_test();

		begin_test("zero_start");
		write_reg(reg_start, '0);
		repeat (10) @(negedge s_clk_in);
		read_reg(reg_start, value);
		check_value("status after zero start", 32'h2, value);
		read_reg(reg_count_a, value);
		check_value("count_a unchanged", last_a, value);
		read_reg(reg_count_b, value);
		check_value("count_b unchanged", last_b, value);
		read_reg(reg_gate, value);
		check_value("gate length unchanged", lens[num_random], value);
		end_test();

		// back to back strobes, one address per cycle
		begin_test("read_latency");
		@(negedge s_clk_in);
		read = 1'b1;
		address = reg_start;
		for (int i = 0; i < 4; i++)
		begin
			@(negedge s_clk_in);
			check_value($sformatf("readdata of address %0d", i), expected_reg(i), readdata);
			address = addr_width'(i + 1);
		end
		read = 1'b0;
		repeat (2) @(negedge s_clk_in);
		check_value("readdata held without strobe", lens[num_random], readdata);
		end_test();

		$display("tests run %0d, passed %0d, failed %0d, errors %0d", tests_run,
			tests_passed, tests_run - tests_passed, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/clock_meter_pkg.sv
`default_nettype none

package clock_meter_pkg;

	// bus data and both counts share this width
	localparam int data_width = 32;

	// four registers on the host bus
	localparam int addr_width = 2;

	// write: start with gate length, read: status word
	localparam logic [addr_width-1:0] reg_start = 2'd0;

	// captured counts, read only
	localparam logic [addr_width-1:0] reg_count_a = 2'd1;
	localparam logic [addr_width-1:0] reg_count_b = 2'd2;

	// gate length of the last accepted start
	localparam logic [addr_width-1:0] reg_gate = 2'd3;

	// status word bit positions
	localparam int status_busy_bit = 0;
	localparam int status_valid_bit = 1;

	// flops in every synchronizer chain
	localparam int sync_stages = 2;

endpackage

`default_nettype wire

//--- rtl/clock_meter_top.sv
`timescale 1ns/1ps
`default_nettype none

module clock_meter_top
	import clock_meter_pkg::*;
(
	input  logic                  s_clk_in,
	input  logic                  s_reset_in,
	input  logic [addr_width-1:0] address,
	input  logic                  read,
	input  logic                  write,
	input  logic [data_width-1:0] writedata,
	output logic [data_width-1:0] readdata,
	input  logic                  clk_a,
	input  logic                  clk_b
);

	logic                  start;
	logic [data_width-1:0] gate_len;
	logic                  gate;
	logic                  busy;
	logic                  accepted;
	logic                  capture_done;
	logic                  valid;
	logic [data_width-1:0] count_a_raw;
	logic [data_width-1:0] count_b_raw;
	logic                  done_a_tgl;
	logic                  done_b_tgl;
	logic [data_width-1:0] count_a;
	logic [data_width-1:0] count_b;

	host_regs host_regs_inst (
		.s_clk_in   (s_clk_in),
		.s_reset_in (s_reset_in),
		.address    (address),
		.read       (read),
		.write      (write),
		.writedata  (writedata),
		.readdata   (readdata),
		.busy       (busy),
		.valid      (valid),
		.count_a    (count_a),
		.count_b    (count_b),
		.start      (start),
		.gate_len   (gate_len)
	);

	gate_timer gate_timer_inst (
		.s_clk_in     (s_clk_in),
		.s_reset_in   (s_reset_in),
		.start        (start),
		.gate_len     (gate_len),
		.capture_done (capture_done),
		.gate         (gate),
		.busy         (busy),
		.accepted     (accepted)
	);

	// one counter per measured clock
	edge_counter counter_a (
		.s_reset_in (s_reset_in),
		.meas_clk   (clk_a),
		.gate       (gate),
		.count      (count_a_raw),
		.done_tgl   (done_a_tgl)
	);

	edge_counter counter_b (
		.s_reset_in (s_reset_in),
		.meas_clk   (clk_b),
		.gate       (gate),
		.count      (count_b_raw),
		.done_tgl   (done_b_tgl)
	);

	count_capture count_capture_inst (
		.s_clk_in     (s_clk_in),
		.s_reset_in   (s_reset_in),
		.accepted     (accepted),
		.done_a_tgl   (done_a_tgl),
		.done_b_tgl   (done_b_tgl),
		.count_a_raw  (count_a_raw),
		.count_b_raw  (count_b_raw),
		.count_a      (count_a),
		.count_b      (count_b),
		.valid        (valid),
		.capture_done (capture_done)
	);

endmodule

`default_nettype wire

//--- rtl/count_capture.sv
`timescale 1ns/1ps
`default_nettype none

module count_capture
	import clock_meter_pkg::*;
(
	input  logic                  s_clk_in,
	input  logic                  s_reset_in,
	input  logic                  accepted,
	input  logic                  done_a_tgl,
	input  logic                  done_b_tgl,
	input  logic [data_width-1:0] count_a_raw,
	input  logic [data_width-1:0] count_b_raw,
	output logic [data_width-1:0] count_a,
	output logic [data_width-1:0] count_b,
	output logic                  valid,
	output logic                  capture_done
);

	logic [sync_stages-1:0] sync_a;
	logic [sync_stages-1:0] sync_b;
	logic                   ref_a;
	logic                   ref_b;
	logic                   pending;
	logic                   both_done;

	always_ff @(posedge s_clk_in or posedge s_reset_in)
	begin
		if (s_reset_in)
		begin
			sync_a <= '0;
			sync_b <= '0;
		end
		else
		begin
			sync_a <= {sync_a[sync_stages-2:0], done_a_tgl};
			sync_b <= {sync_b[sync_stages-2:0], done_b_tgl};
		end
	end

	// each toggle flips once per measurement
	assign both_done = pending && (sync_a[sync_stages-1] != ref_a)
		&& (sync_b[sync_stages-1] != ref_b);

	always_ff @(posedge s_clk_in or posedge s_reset_in)
	begin
		if (s_reset_in)
		begin
			ref_a <= 1'b0;
			ref_b <= 1'b0;
			pending <= 1'b0;
			valid <= 1'b0;
			capture_done <= 1'b0;
			count_a <= '0;
			count_b <= '0;
		end
		else
		begin
			capture_done <= both_done;
			if (accepted)
			begin
				// toggles are settled since the last capture
				ref_a <= sync_a[sync_stages-1];
				ref_b <= sync_b[sync_stages-1];
				pending <= 1'b1;
				valid <= 1'b0;
			end
			else if (both_done)
			begin
				// raw counts are frozen once the toggle has crossed
				count_a <= count_a_raw;
				count_b <= count_b_raw;
				pending <= 1'b0;
				valid <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/edge_counter.sv
`timescale 1ns/1ps
`default_nettype none

module edge_counter
	import clock_meter_pkg::*;
(
	input  logic                  s_reset_in,
	input  logic                  meas_clk,
	input  logic                  gate,
	output logic [data_width-1:0] count,
	output logic                  done_tgl
);

	logic [sync_stages-1:0] gate_sync;
	logic                   gate_s;
	logic                   gate_prev;
	logic                   gate_rise;
	logic                   gate_fall;

	// gate comes from the bus domain
	always_ff @(posedge meas_clk or posedge s_reset_in)
	begin
		if (s_reset_in)
		begin
			gate_sync <= '0;
		end
		else
		begin
			gate_sync <= {gate_sync[sync_stages-2:0], gate};
		end
	end

	assign gate_s = gate_sync[sync_stages-1];

	always_ff @(posedge meas_clk or posedge s_reset_in)
	begin
		if (s_reset_in)
		begin
			gate_prev <= 1'b0;
		end
		else
		begin
			gate_prev <= gate_s;
		end
	end

	assign gate_rise = gate_s && !gate_prev;
	assign gate_fall = !gate_s && gate_prev;

	// the rise edge is the first counted edge
	always_ff @(posedge meas_clk or posedge s_reset_in)
	begin
		if (s_reset_in)
		begin
			count <= '0;
		end
		else if (gate_rise)
		begin
			count <= data_width'(1);
		end
		else if (gate_s)
		begin
			count <= count + 1'b1;
		end
	end

	// count is frozen from here until the next rise
	always_ff @(posedge meas_clk or posedge s_reset_in)
	begin
		if (s_reset_in)
			done_tgl <= 1'b0;
		else if (gate_fall)
			done_tgl <= ~done_tgl;
	end

endmodule

`default_nettype wire

//--- rtl/gate_timer.sv
`timescale 1ns/1ps
`default_nettype none

module gate_timer
	import clock_meter_pkg::*;
(
	input  logic                  s_clk_in,
	input  logic                  s_reset_in,
	input  logic                  start,
	input  logic [data_width-1:0] gate_len,
	input  logic                  capture_done,
	output logic                  gate,
	output logic                  busy,
	output logic                  accepted
);

	logic [data_width-1:0] remaining;
	logic                  take;

	// a start while busy is dropped
	assign take = start && !busy;

	always_ff @(posedge s_clk_in or posedge s_reset_in)
	begin
		if (s_reset_in)
		begin
			gate <= 1'b0;
			busy <= 1'b0;
			accepted <= 1'b0;
			remaining <= '0;
		end
		else
		begin
			accepted <= take;
			if (take)
			begin
				gate <= 1'b1;
				busy <= 1'b1;
				remaining <= gate_len;
			end
			else
			begin
				if (gate)
				begin
					// last gate cycle when one remains
					if (remaining == 1)
						gate <= 1'b0;
					remaining <= remaining - 1'b1;
				end
				// busy covers gate plus the trip back through capture
				if (capture_done)
					busy <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/host_regs.sv
`timescale 1ns/1ps
`default_nettype none

module host_regs
	import clock_meter_pkg::*;
(
	input  logic                  s_clk_in,
	input  logic                  s_reset_in,
	input  logic [addr_width-1:0] address,
	input  logic                  read,
	input  logic                  write,
	input  logic [data_width-1:0] writedata,
	output logic [data_width-1:0] readdata,
	input  logic                  busy,
	input  logic                  valid,
	input  logic [data_width-1:0] count_a,
	input  logic [data_width-1:0] count_b,
	output logic                  start,
	output logic [data_width-1:0] gate_len
);

	logic                  start_wr;
	logic [data_width-1:0] gate_reg;
	logic [data_width-1:0] status_word;

	// zero length starts nothing
	assign start_wr = write && (address == reg_start) && (writedata != '0);

	always_comb
	begin
		status_word = '0;
		status_word[status_busy_bit] = busy;
		status_word[status_valid_bit] = valid;
	end

	always_ff @(posedge s_clk_in or posedge s_reset_in)
	begin
		if (s_reset_in)
		begin
			start <= 1'b0;
		end
		else
		begin
			start <= start_wr;
		end
	end

	// length travels with the start pulse
	always_ff @(posedge s_clk_in)
	begin
		if (start_wr)
		begin
			gate_len <= writedata;
		end
	end

	// same acceptance rule as the gate timer, busy still low here
	always_ff @(posedge s_clk_in or posedge s_reset_in)
	begin
		if (s_reset_in)
		begin
			gate_reg <= '0;
		end
		else if (start && !busy)
		begin
			gate_reg <= gate_len;
		end
	end

	// registered read mux, one cycle latency
	always_ff @(posedge s_clk_in or posedge s_reset_in)
	begin
		if (s_reset_in)
		begin
			readdata <= '0;
		end
		else if (read)
		begin
			case (address)
				reg_start:   readdata <= status_word;
				reg_count_a: readdata <= count_a;
				reg_count_b: readdata <= count_b;
				reg_gate:    readdata <= gate_reg;
				default:     readdata <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- sources.f
rtl/clock_meter_pkg.sv
rtl/host_regs.sv
rtl/gate_timer.sv
rtl/edge_counter.sv
rtl/count_capture.sv
rtl/clock_meter_top.sv
bench/clock_meter_tb.sv
